// File: src/adc_pkg.sv
package adc_pkg;

  typedef enum logic [2:0] {
    SEQ_IDLE    = 3'd0,
    SEQ_STROBE  = 3'd1,
    SEQ_CONVERT = 3'd2,
    SEQ_WAITING = 3'd3,
    SEQ_DONE    = 3'd4
  } adc_seq_state_e;

  localparam int NUM_CHANNELS = 32;
  localparam int CHAN_W       = $clog2(NUM_CHANNELS);
  localparam int RESULT_W     = 12;
  localparam int ACC_W        = 15; // 12 bits plus 8 samples
  localparam int NUM_CMON     = 10;
  localparam int NUM_TMON     = 11;

  localparam logic [15:0] REG_BYPASS_HI   = 16'h0000;
  localparam logic [15:0] REG_BYPASS_LO   = 16'h0001;
  localparam logic [15:0] REG_CMON_EN     = 16'h0002;
  localparam logic [15:0] REG_TMON_EN     = 16'h0003;
  localparam logic [15:0] REG_ADC_EN      = 16'h0004;
  localparam logic [15:0] REG_AVG_LOG2    = 16'h0005;
  localparam logic [15:0] REG_STATUS      = 16'h0006;
  localparam logic [15:0] REG_RESULT_BASE = 16'h0020;

  // current monitor i sits on channel 3i+2
  localparam logic [CHAN_W-1:0] CMON_CHANNELS [NUM_CMON] = '{
    5'd2, 5'd5, 5'd8, 5'd11, 5'd14, 5'd17, 5'd20, 5'd23, 5'd26, 5'd29
  };

  // temp monitors on 3i+3, last one on channel 31
  localparam logic [CHAN_W-1:0] TMON_CHANNELS [NUM_TMON] = '{
    5'd3, 5'd6, 5'd9, 5'd12, 5'd15, 5'd18, 5'd21, 5'd24, 5'd27, 5'd30, 5'd31
  };

  function automatic logic [NUM_CMON-1:0] cmon_select(input logic [CHAN_W-1:0] chan);
    logic [NUM_CMON-1:0] sel;
    sel = '0;
    for (int i = 0; i < NUM_CMON; i++) begin
      sel[i] = (chan == CMON_CHANNELS[i]);
    end
    return sel;
  endfunction

  function automatic logic [NUM_TMON-1:0] tmon_select(input logic [CHAN_W-1:0] chan);
    logic [NUM_TMON-1:0] sel;
    sel = '0;
    for (int i = 0; i < NUM_TMON; i++) begin
      sel[i] = (chan == TMON_CHANNELS[i]);
    end
    return sel;
  endfunction

endpackage

// File: src/adc_result_store.sv
`timescale 1ns/1ps

module adc_result_store (
  input  logic                         wb_clk_i,
  input  logic                         wb_rst_i,
  input  logic                         wr_en_i,
  input  logic [adc_pkg::CHAN_W-1:0]   wr_addr_i,
  input  logic [adc_pkg::RESULT_W-1:0] wr_data_i,
  input  logic [adc_pkg::CHAN_W-1:0]   rd_addr_i,
  output logic [adc_pkg::RESULT_W-1:0] rd_data_o
);

  // last mean per channel
  logic [adc_pkg::RESULT_W-1:0] mem [adc_pkg::NUM_CHANNELS];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int i = 0; i < adc_pkg::NUM_CHANNELS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read lines up with the bus ack
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rd_data_o <= '0;
    end else begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

// File: src/adc_averager.sv
`timescale 1ns/1ps

module adc_averager (
  input  logic                         wb_clk_i,
  input  logic                         wb_rst_i,
  input  logic                         sample_valid_i,
  input  logic                         sample_first_i,
  input  logic                         sample_last_i,
  input  logic [adc_pkg::RESULT_W-1:0] sample_i,
  input  logic [adc_pkg::CHAN_W-1:0]   channel_i,
  input  logic [1:0]                   avg_log2_i,
  output logic                         result_stb_o,
  output logic [adc_pkg::RESULT_W-1:0] result_o,
  output logic [adc_pkg::CHAN_W-1:0]   result_channel_o
);

  logic [adc_pkg::ACC_W-1:0] acc;
  logic [adc_pkg::ACC_W-1:0] sum_next;
  logic [adc_pkg::ACC_W-1:0] mean;

  // first sample restarts the sum
  assign sum_next = (sample_first_i ? '0 : acc) + adc_pkg::ACC_W'(sample_i);
  assign mean     = sum_next >> avg_log2_i;

  always_ff @(posedge wb_clk_i) begin
    if (sample_valid_i) begin
      acc <= sum_next;
    end
    if (sample_valid_i && sample_last_i) begin
      result_o         <= mean[adc_pkg::RESULT_W-1:0];
      result_channel_o <= channel_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      result_stb_o <= 1'b0;
    end else begin
      result_stb_o <= sample_valid_i && sample_last_i; // one cycle after the sample
    end
  end

endmodule

// File: src/adc_regs.sv
`timescale 1ns/1ps

module adc_regs #(
  parameter logic [1:0] DEFAULT_AVG_LOG2 = 2'd2
) (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [15:0]                        wb_adr_i,
  input  logic [15:0]                        wb_dat_i,
  output logic [15:0]                        wb_dat_o,
  output logic                               wb_ack_o,
  input  adc_pkg::adc_seq_state_e            seq_state_i,
  input  logic                               adc_calibrate_i,
  input  logic                               adc_datavalid_i,
  input  logic                               adc_busy_i,
  input  logic                               adc_sample_i,
  input  logic [adc_pkg::RESULT_W-1:0]       rd_data_i,
  output logic [adc_pkg::NUM_CHANNELS-1:0]   bypass_o,
  output logic [adc_pkg::NUM_CMON-1:0]       cmon_en_o,
  output logic [adc_pkg::NUM_TMON-1:0]       tmon_en_o,
  output logic                               adc_en_o,
  output logic [1:0]                         avg_log2_o,
  output logic [adc_pkg::CHAN_W-1:0]         rd_addr_o
);

  typedef enum logic [3:0] {
    SRC_NONE,
    SRC_BYPASS_HI,
    SRC_BYPASS_LO,
    SRC_CMON,
    SRC_TMON,
    SRC_EN,
    SRC_AVG,
    SRC_STATUS,
    SRC_RESULT
  } rd_src_e;

  rd_src_e     rd_src;
  logic        access;
  logic        result_hit;
  logic [15:0] result_offset;

  assign access = wb_cyc_i && wb_stb_i && !wb_ack_o; // no back-to-back ack

  assign result_hit = (wb_adr_i >= adc_pkg::REG_RESULT_BASE) &&
                      (wb_adr_i < adc_pkg::REG_RESULT_BASE + 16'(adc_pkg::NUM_CHANNELS));

  // store read is registered, data lands in the ack cycle
  assign result_offset = wb_adr_i - adc_pkg::REG_RESULT_BASE;
  assign rd_addr_o     = result_offset[adc_pkg::CHAN_W-1:0];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      rd_src     <= SRC_NONE;
      bypass_o   <= '0;
      cmon_en_o  <= '1;
      tmon_en_o  <= '1;
      adc_en_o   <= 1'b1;
      avg_log2_o <= DEFAULT_AVG_LOG2;
    end else begin
      wb_ack_o <= access;
      if (access) begin
        case (wb_adr_i)
          adc_pkg::REG_BYPASS_HI: begin
            rd_src <= SRC_BYPASS_HI;
            if (wb_we_i) bypass_o[31:16] <= wb_dat_i;
          end
          adc_pkg::REG_BYPASS_LO: begin
            rd_src <= SRC_BYPASS_LO;
            if (wb_we_i) bypass_o[15:0] <= wb_dat_i;
          end
          adc_pkg::REG_CMON_EN: begin
            rd_src <= SRC_CMON;
            if (wb_we_i) cmon_en_o <= wb_dat_i[adc_pkg::NUM_CMON-1:0];
          end
          adc_pkg::REG_TMON_EN: begin
            rd_src <= SRC_TMON;
            if (wb_we_i) tmon_en_o <= wb_dat_i[adc_pkg::NUM_TMON-1:0];
          end
          adc_pkg::REG_ADC_EN: begin
            rd_src <= SRC_EN;
            if (wb_we_i) adc_en_o <= wb_dat_i[0];
          end
          adc_pkg::REG_AVG_LOG2: begin
            rd_src <= SRC_AVG;
            if (wb_we_i) avg_log2_o <= wb_dat_i[1:0];
          end
          adc_pkg::REG_STATUS: rd_src <= SRC_STATUS; // read only
          default: rd_src <= result_hit ? SRC_RESULT : SRC_NONE;
        endcase
      end
    end
  end

  always_comb begin
    case (rd_src)
      SRC_BYPASS_HI: wb_dat_o = bypass_o[31:16];
      SRC_BYPASS_LO: wb_dat_o = bypass_o[15:0];
      SRC_CMON:      wb_dat_o = {6'b0, cmon_en_o};
      SRC_TMON:      wb_dat_o = {5'b0, tmon_en_o};
      SRC_EN:        wb_dat_o = {15'b0, adc_en_o};
      SRC_AVG:       wb_dat_o = {14'b0, avg_log2_o};
      SRC_STATUS:    wb_dat_o = {9'b0, seq_state_i, adc_busy_i, adc_sample_i,
                                 adc_datavalid_i, adc_calibrate_i};
      SRC_RESULT:    wb_dat_o = {4'b0, rd_data_i};
      default:       wb_dat_o = 16'h0000;
    endcase
  end

endmodule

// File: src/adc_sequencer.sv
`timescale 1ns/1ps

module adc_sequencer #(
  parameter int STB_WIDTH = 400
) (
  input  logic                             wb_clk_i,
  input  logic                             wb_rst_i,
  input  logic [adc_pkg::NUM_CHANNELS-1:0] bypass_i,
  input  logic [adc_pkg::NUM_CMON-1:0]     cmon_en_i,
  input  logic [adc_pkg::NUM_TMON-1:0]     tmon_en_i,
  input  logic                             adc_en_i,
  input  logic [1:0]                       avg_log2_i,
  input  logic                             adc_calibrate_i,
  input  logic                             adc_busy_i,
  input  logic                             adc_datavalid_i,
  output logic                             adc_start_o,
  output logic [adc_pkg::CHAN_W-1:0]       adc_chnum_o,
  output logic [adc_pkg::NUM_CMON-1:0]     current_stb_o,
  output logic [adc_pkg::NUM_TMON-1:0]     temp_stb_o,
  output adc_pkg::adc_seq_state_e          state_o,
  output logic                             sample_valid_o,
  output logic                             sample_first_o,
  output logic                             sample_last_o
);

  localparam int STB_CNT_W = $clog2(STB_WIDTH + 1);

  adc_pkg::adc_seq_state_e    state;
  logic [STB_CNT_W-1:0]       stb_cnt;
  logic [2:0]                 conv_cnt;      // conversions done on this channel
  logic [2:0]                 conv_last_cnt;
  logic                       chan_complete;
  logic [adc_pkg::NUM_CMON-1:0] cmon_hit;
  logic [adc_pkg::NUM_TMON-1:0] tmon_hit;
  logic                       accept;

  assign cmon_hit = adc_pkg::cmon_select(adc_chnum_o) & cmon_en_i;
  assign tmon_hit = adc_pkg::tmon_select(adc_chnum_o) & tmon_en_i;

  // 2^n - 1 in three bits, wraps to 7 for n = 3
  assign conv_last_cnt = (3'd1 << avg_log2_i) - 3'd1;

  // datavalid counts only once a start is out
  assign accept = adc_datavalid_i &&
                  (state == adc_pkg::SEQ_CONVERT || state == adc_pkg::SEQ_WAITING);

  assign sample_valid_o = accept;
  assign sample_first_o = (conv_cnt == 3'd0);
  assign sample_last_o  = (conv_cnt >= conv_last_cnt);
  assign state_o        = state;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state         <= adc_pkg::SEQ_IDLE;
      adc_start_o   <= 1'b0;
      adc_chnum_o   <= '0;
      current_stb_o <= '0;
      temp_stb_o    <= '0;
      stb_cnt       <= '0;
      conv_cnt      <= '0;
      chan_complete <= 1'b0;
    end else begin
      case (state)
        adc_pkg::SEQ_IDLE: begin
          if (adc_en_i && !adc_calibrate_i) begin
            if (bypass_i[adc_chnum_o]) begin
              chan_complete <= 1'b1; // skip, no conversion
              state         <= adc_pkg::SEQ_DONE;
            end else if (|cmon_hit || |tmon_hit) begin
              current_stb_o <= cmon_hit;
              temp_stb_o    <= tmon_hit;
              stb_cnt       <= STB_CNT_W'(STB_WIDTH);
              state         <= adc_pkg::SEQ_STROBE;
            end else begin
              adc_start_o <= 1'b1;
              state       <= adc_pkg::SEQ_CONVERT;
            end
          end
        end
        adc_pkg::SEQ_STROBE: begin
          if (stb_cnt != '0) begin
            stb_cnt <= stb_cnt - 1'b1;
          end else begin
            adc_start_o <= 1'b1; // excite settled
            state       <= adc_pkg::SEQ_CONVERT;
          end
        end
        adc_pkg::SEQ_CONVERT, adc_pkg::SEQ_WAITING: begin
          if (accept) begin
            adc_start_o   <= 1'b0;
            current_stb_o <= '0;
            temp_stb_o    <= '0;
            chan_complete <= sample_last_o;
            state         <= adc_pkg::SEQ_DONE;
          end else if (adc_busy_i) begin
            adc_start_o <= 1'b0;
            state       <= adc_pkg::SEQ_WAITING;
          end
        end
        adc_pkg::SEQ_DONE: begin
          if (chan_complete) begin
            conv_cnt    <= '0;
            adc_chnum_o <= adc_chnum_o + 1'b1; // wraps 31 -> 0
          end else begin
            conv_cnt <= conv_cnt + 1'b1;
          end
          state <= adc_pkg::SEQ_IDLE;
        end
        default: state <= adc_pkg::SEQ_IDLE;
      endcase
    end
  end

endmodule

// File: src/adc_subsystem.sv
`timescale 1ns/1ps

module adc_subsystem #(
  parameter int         STB_WIDTH        = 400,
  parameter logic [1:0] DEFAULT_AVG_LOG2 = 2'd2
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [15:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic        adc_calibrate_i,
  input  logic        adc_datavalid_i,
  input  logic        adc_busy_i,
  input  logic        adc_sample_i,
  input  logic [11:0] adc_result_i,
  output logic        adc_start_o,
  output logic [4:0]  adc_chnum_o,
  output logic        result_stb_o,
  output logic [11:0] result_o,
  output logic [4:0]  result_channel_o,
  output logic [9:0]  current_stb_o,
  output logic [10:0] temp_stb_o
);

  logic [adc_pkg::NUM_CHANNELS-1:0] bypass;
  logic [adc_pkg::NUM_CMON-1:0]     cmon_en;
  logic [adc_pkg::NUM_TMON-1:0]     tmon_en;
  logic                             adc_en;
  logic [1:0]                       avg_log2;
  logic [adc_pkg::CHAN_W-1:0]       rd_addr;
  logic [adc_pkg::RESULT_W-1:0]     rd_data;
  adc_pkg::adc_seq_state_e          seq_state;
  logic                             sample_valid;
  logic                             sample_first;
  logic                             sample_last;

  adc_regs #(
    .DEFAULT_AVG_LOG2 (DEFAULT_AVG_LOG2)
  ) u_regs (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
    .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .seq_state_i     (seq_state),
    .adc_calibrate_i, .adc_datavalid_i, .adc_busy_i, .adc_sample_i,
    .rd_data_i       (rd_data),
    .bypass_o        (bypass),
    .cmon_en_o       (cmon_en),
    .tmon_en_o       (tmon_en),
    .adc_en_o        (adc_en),
    .avg_log2_o      (avg_log2),
    .rd_addr_o       (rd_addr)
  );

  adc_sequencer #(
    .STB_WIDTH (STB_WIDTH)
  ) u_sequencer (
    .wb_clk_i, .wb_rst_i,
    .bypass_i        (bypass),
    .cmon_en_i       (cmon_en),
    .tmon_en_i       (tmon_en),
    .adc_en_i        (adc_en),
    .avg_log2_i      (avg_log2),
    .adc_calibrate_i, .adc_busy_i, .adc_datavalid_i,
    .adc_start_o, .adc_chnum_o, .current_stb_o, .temp_stb_o,
    .state_o         (seq_state),
    .sample_valid_o  (sample_valid),
    .sample_first_o  (sample_first),
    .sample_last_o   (sample_last)
  );

  adc_averager u_averager (
    .wb_clk_i, .wb_rst_i,
    .sample_valid_i  (sample_valid),
    .sample_first_i  (sample_first),
    .sample_last_i   (sample_last),
    .sample_i        (adc_result_i),
    .channel_i       (adc_chnum_o),
    .avg_log2_i      (avg_log2),
    .result_stb_o, .result_o, .result_channel_o
  );

  // store follows the result stream
  adc_result_store u_store (
    .wb_clk_i, .wb_rst_i,
    .wr_en_i   (result_stb_o),
    .wr_addr_i (result_channel_o),
    .wr_data_i (result_o),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

endmodule

// File: test/adc_model.sv
`timescale 1ns/1ps

module adc_model (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        start_i,
  input  logic [4:0]  chnum_i,
  output logic        calibrate_o,
  output logic        busy_o,
  output logic        sample_o,
  output logic        datavalid_o,
  output logic [11:0] result_o
);

  int          cal_cnt = 5;
  int          busy_len;
  logic [11:0] value;
  logic [4:0]  chan;

  // every conversion in order, read by the testbench
  logic [4:0]  log_chan[$];
  logic [11:0] log_val[$];

  always @(posedge wb_clk_i) begin
    if (wb_rst_i) cal_cnt <= 5;
    else if (cal_cnt != 0) cal_cnt <= cal_cnt - 1;
  end

  assign calibrate_o = (cal_cnt != 0);

  initial begin
    busy_o      = 1'b0;
    sample_o    = 1'b0;
    datavalid_o = 1'b0;
    result_o    = '0;
    forever begin
      @(posedge wb_clk_i);
      #1;
      if (start_i && !wb_rst_i) begin
        chan     = chnum_i;
        busy_len = 3 + int'($urandom % 6);
        repeat (1) @(posedge wb_clk_i); // busy on the second edge
        #2;
        busy_o   = 1'b1;
        sample_o = 1'b1; // track phase
        @(posedge wb_clk_i);
        #2;
        sample_o = 1'b0;
        repeat (busy_len - 1) @(posedge wb_clk_i);
        #2;
        value       = 12'($urandom);
        busy_o      = 1'b0;
        datavalid_o = 1'b1;
        result_o    = value;
        log_chan.push_back(chan);
        log_val.push_back(value);
        @(posedge wb_clk_i);
        #2;
        datavalid_o = 1'b0;
      end
    end
  end

endmodule

// File: test/adc_subsystem_properties.sv
`timescale 1ns/1ps

module adc_subsystem_properties #(
  parameter int STB_WIDTH = 6
) (
  input logic        wb_clk_i,
  input logic        wb_rst_i,
  input logic        wb_ack_o,
  input logic        adc_start_o,
  input logic [4:0]  adc_chnum_o,
  input logic [9:0]  current_stb_o,
  input logic [10:0] temp_stb_o,
  input logic [9:0]  cmon_en_i,
  input logic [10:0] tmon_en_i
);

  logic [9:0]  cmon_exp;
  logic [10:0] tmon_exp;
  logic        any_stb;

  always_comb begin
    cmon_exp = '0;
    tmon_exp = '0;
    if (adc_chnum_o >= 5'd2 && (adc_chnum_o - 5'd2) % 3 == 0) begin
      cmon_exp[(adc_chnum_o - 2) / 3] = 1'b1;
    end
    if (adc_chnum_o == 5'd31) tmon_exp[10] = 1'b1;
    else if (adc_chnum_o >= 5'd3 && adc_chnum_o % 3 == 0) tmon_exp[adc_chnum_o / 3 - 1] = 1'b1;
  end

  assign any_stb = |current_stb_o || |temp_stb_o;

  // excite must settle before the conversion starts
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(adc_start_o) && any_stb |-> $past(any_stb, STB_WIDTH))
    else $error("start rose before the monitor strobe was held long enough");

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    |current_stb_o |-> current_stb_o == (cmon_exp & cmon_en_i))
    else $error("current strobe does not match the channel map");

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    |temp_stb_o |-> temp_stb_o == (tmon_exp & tmon_en_i))
    else $error("temp strobe does not match the channel map");

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("ack held longer than one cycle");

endmodule

bind adc_subsystem adc_subsystem_properties #(.STB_WIDTH(STB_WIDTH)) i_props (
  .wb_clk_i      (wb_clk_i),
  .wb_rst_i      (wb_rst_i),
  .wb_ack_o      (wb_ack_o),
  .adc_start_o   (adc_start_o),
  .adc_chnum_o   (adc_chnum_o),
  .current_stb_o (current_stb_o),
  .temp_stb_o    (temp_stb_o),
  .cmon_en_i     (cmon_en),
  .tmon_en_i     (tmon_en)
);

// File: test/tb_adc_subsystem.sv
`timescale 1ns/1ps

module tb_adc_subsystem;

  localparam int CONV_BOUND = 30; // worst case cycles per conversion
  localparam int TOTAL_CONV = 32 + 32 + 20 + 32;
  localparam int MAX_CYCLES = (TOTAL_CONV * CONV_BOUND + 600) * 2;

  logic        wb_clk = 1'b0;
  logic        wb_rst, wb_cyc, wb_stb, wb_we, wb_ack;
  logic [15:0] wb_adr, wb_dat, wb_dat_o;
  logic        adc_cal, adc_dv, adc_busy, adc_sample, adc_start;
  logic [11:0] adc_result, result;
  logic [4:0]  adc_chnum, result_chan;
  logic        result_stb;
  logic [9:0]  current_stb;
  logic [10:0] temp_stb;

  int          n_checks, n_err, rcount, cycles, stb_hits, exp_next;
  bit          order_known, stb_check_on;
  logic [31:0] bypass_tb;
  logic [9:0]  cmon_tb;
  logic [10:0] tmon_tb;
  int          avg_tb;
  logic [11:0] last_result[32];
  bit          seen[32];

  always #10 wb_clk = ~wb_clk;

  adc_subsystem #(.STB_WIDTH(6), .DEFAULT_AVG_LOG2(2'd2)) i_dut (
    .wb_clk_i(wb_clk), .wb_rst_i(wb_rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
    .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack), .adc_calibrate_i(adc_cal), .adc_datavalid_i(adc_dv),
    .adc_busy_i(adc_busy), .adc_sample_i(adc_sample), .adc_result_i(adc_result),
    .adc_start_o(adc_start), .adc_chnum_o(adc_chnum), .result_stb_o(result_stb),
    .result_o(result), .result_channel_o(result_chan), .current_stb_o(current_stb),
    .temp_stb_o(temp_stb)
  );

  adc_model i_model (
    .wb_clk_i(wb_clk), .wb_rst_i(wb_rst), .start_i(adc_start), .chnum_i(adc_chnum),
    .calibrate_o(adc_cal), .busy_o(adc_busy), .sample_o(adc_sample),
    .datavalid_o(adc_dv), .result_o(adc_result)
  );

  function automatic int ref_mean(input int unsigned sum, input int log2n);
    return int'(sum >> log2n);
  endfunction

  function automatic int cmon_bit(input int ch);
    if (ch >= 2 && (ch - 2) % 3 == 0) return 1 << ((ch - 2) / 3);
    return 0;
  endfunction

  function automatic int tmon_bit(input int ch);
    if (ch == 31) return 1 << 10;
    if (ch >= 3 && ch % 3 == 0) return 1 << (ch / 3 - 1);
    return 0;
  endfunction

  function automatic int next_active(input int ch);
    int c;
    c = (ch + 1) % 32;
    while (bypass_tb[c]) c = (c + 1) % 32;
    return c;
  endfunction

  task automatic check(input string what, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      n_err++;
      $display("[ERROR] %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic bus_access(input logic we, input logic [15:0] adr, input logic [15:0] wdat,
                            output logic [15:0] rdat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = wdat;
    do begin
      @(posedge wb_clk);
      #1;
    end while (!wb_ack);
    rdat = wb_dat_o;
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reg_write(input logic [15:0] adr, input logic [15:0] dat);
    logic [15:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic reg_check(input string what, input logic [15:0] adr, input int exp);
    logic [15:0] rd;
    bus_access(1'b0, adr, 16'h0, rd);
    check(what, int'(rd), exp);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge wb_clk);
    #2;
  endtask

  task automatic wait_results(input int n);
    int target;
    target = rcount + n;
    while (rcount < target) idle_cycles(1);
  endtask

  // polls the status word until the FSM rests in idle
  task automatic wait_seq_idle();
    logic [15:0] st;
    do begin
      bus_access(1'b0, 16'h0006, 16'h0, st);
    end while (st[6:4] != 3'd0); // state field
  endtask

  // stop the scan and skip past any partly averaged channel
  task automatic flush_scan();
    reg_write(16'h0004, 16'h0);
    wait_seq_idle();
    reg_write(16'h0000, 16'hffff);
    reg_write(16'h0001, 16'hffff);
    reg_write(16'h0004, 16'h1);
    idle_cycles(6);
    reg_write(16'h0004, 16'h0);
    wait_seq_idle();
    order_known = 1'b0;
  endtask

  task automatic set_bypass(input logic [31:0] mask);
    bypass_tb = mask;
    reg_write(16'h0000, mask[31:16]);
    reg_write(16'h0001, mask[15:0]);
  endtask

  task automatic test_done(input string name);
    $display("test %s finished, %0d errors so far", name, n_err);
  endtask

  // compares every streamed result with the logged conversions
  always begin : compare
    int unsigned sum;
    int          n;
    int          ch;
    @(posedge wb_clk);
    #1;
    if (!wb_rst && result_stb) begin
      ch  = int'(result_chan);
      sum = 0;
      n   = 0;
      while (i_model.log_chan.size() > 0 && int'(i_model.log_chan[0]) != ch) begin
        void'(i_model.log_chan.pop_front()); // remnant of a skipped channel
        void'(i_model.log_val.pop_front());
      end
      while (i_model.log_chan.size() > 0 && int'(i_model.log_chan[0]) == ch) begin
        void'(i_model.log_chan.pop_front());
        sum += i_model.log_val.pop_front();
        n++;
      end
      check("samples per result", n, 1 << avg_tb);
      check("averaged result", int'(result), ref_mean(sum, avg_tb));
      check("bypassed channel streamed", int'(bypass_tb[ch]), 0);
      if (order_known) check("scan order", ch, exp_next);
      exp_next         = next_active(ch);
      order_known      = 1'b1;
      last_result[ch]  = result;
      seen[ch]         = 1'b1;
      rcount++;
    end
  end

  always begin : strobe_watch
    int exp_c;
    int exp_t;
    @(posedge wb_clk);
    #1;
    if (!wb_rst && adc_busy) check("start low while busy", int'(adc_start), 0);
    if (stb_check_on) begin
      exp_c = cmon_bit(int'(adc_chnum)) & int'(cmon_tb);
      exp_t = tmon_bit(int'(adc_chnum)) & int'(tmon_tb);
      if (adc_busy) begin
        check("current strobe in conversion", int'(current_stb), exp_c);
        check("temp strobe in conversion", int'(temp_stb), exp_t);
        if (exp_c != 0 || exp_t != 0) stb_hits++;
      end else begin
        if (current_stb != 0) check("current strobe map", int'(current_stb), exp_c);
        if (temp_stb != 0) check("temp strobe map", int'(temp_stb), exp_t);
      end
    end
  end

  always @(posedge wb_clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run exceeded %0d cycles, results seen %0d", MAX_CYCLES, rcount);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hacac_ed99));
    wb_rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_adr = '0;
    wb_dat = '0;
    bypass_tb = '0;
    cmon_tb = '1;
    tmon_tb = '1;
    avg_tb = 2;
    repeat (2) @(posedge wb_clk);
    #2;
    wb_rst = 1'b0;

    // calibrate still holds the sequencer here
    reg_check("adc enable default", 16'h0004, 1);
    reg_check("status during calibrate", 16'h0006, 16'h0001);
    reg_write(16'h0004, 16'h0);
    reg_check("adc enable", 16'h0004, 0);
    reg_check("bypass hi default", 16'h0000, 0);
    reg_check("bypass lo default", 16'h0001, 0);
    reg_check("cmon enable default", 16'h0002, 16'h03ff);
    reg_check("tmon enable default", 16'h0003, 16'h07ff);
    reg_check("avg default", 16'h0005, 2);
    reg_write(16'h0000, 16'ha5a5);
    reg_write(16'h0001, 16'h5a5a);
    reg_write(16'h0002, 16'h0155);
    reg_write(16'h0003, 16'h02aa);
    reg_write(16'h0005, 16'h0001);
    reg_check("bypass hi", 16'h0000, 16'ha5a5);
    reg_check("bypass lo", 16'h0001, 16'h5a5a);
    reg_check("cmon enable", 16'h0002, 16'h0155);
    reg_check("tmon enable", 16'h0003, 16'h02aa);
    reg_check("avg", 16'h0005, 1);
    reg_check("unmapped address", 16'h0010, 0);
    test_done("register access");

    set_bypass(32'h0);
    cmon_tb = '0;
    tmon_tb = '0;
    reg_write(16'h0002, 16'h0);
    reg_write(16'h0003, 16'h0);
    avg_tb = 0;
    reg_write(16'h0005, 16'h0);
    exp_next = 0;
    order_known = 1'b1;
    reg_write(16'h0004, 16'h1);
    wait_results(32);
    test_done("single conversion scan");

    flush_scan();
    set_bypass(32'h0);
    avg_tb = 2;
    reg_write(16'h0005, 16'h2);
    reg_write(16'h0004, 16'h1);
    wait_results(8);
    test_done("averaging by four");

    flush_scan();
    avg_tb = 0;
    reg_write(16'h0005, 16'h0);
    set_bypass(32'h0f0f_00f0);
    reg_write(16'h0004, 16'h1);
    wait_results(20);
    test_done("bypass");

    flush_scan();
    set_bypass(32'h0);
    cmon_tb = '1;
    tmon_tb = '1;
    reg_write(16'h0002, 16'h03ff);
    reg_write(16'h0003, 16'h07ff);
    stb_check_on = 1'b1;
    reg_write(16'h0004, 16'h1);
    wait_results(32);
    reg_write(16'h0004, 16'h0);
    wait_seq_idle();
    stb_check_on = 1'b0;
    check("monitor strobes seen in conversion", int'(stb_hits > 20), 1);
    test_done("monitor strobes");

    for (int c = 0; c < 32; c++) begin
      if (seen[c]) reg_check("stored result", 16'h0020 + 16'(c), int'(last_result[c]));
    end
    test_done("result readback");

    $display("checks %0d, errors %0d, results %0d", n_checks, n_err, rcount);
    if (n_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
src/adc_pkg.sv
src/adc_result_store.sv
src/adc_averager.sv
src/adc_regs.sv
src/adc_sequencer.sv
src/adc_subsystem.sv
test/adc_model.sv
test/adc_subsystem_properties.sv
test/tb_adc_subsystem.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_adc_subsystem -f vlog.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Regression passed"; then
  exit 0
fi
exit 1
